/* i2c_cfg.svh */
// bus timing, device address and delay constants, included by the RTL and the testbench
`ifndef I2C_CFG_SVH
`define I2C_CFG_SVH

// ----------------------------------------------------------------------
// clocks
// ----------------------------------------------------------------------
`define I2C_CLK_FREQ       10_000_000                     // system clock, hz
`define I2C_BUS_FREQ       200_000                        // scl rate, hz
`define I2C_BIT_CYCLES     (`I2C_CLK_FREQ / `I2C_BUS_FREQ) // clk cycles per scl bit

// ----------------------------------------------------------------------
// slave and delays
// ----------------------------------------------------------------------
`define I2C_DEVICE_ADDR    8'h6C                          // 7-bit addr plus write bit

`define I2C_MS_CYCLES      (`I2C_CLK_FREQ / 1000)         // clk cycles per ms tick

// slave settling time after reset, one ms
`define I2C_POWERUP_CYCLES `I2C_MS_CYCLES

`endif

/* i2c_cfg_pkg.sv */
// types shared by the I2C config master blocks, referenced by scoped name
`default_nettype none

package i2c_cfg_pkg;

	// ----------------------------------------------------------------------
	// table entry and its fields
	// ----------------------------------------------------------------------
	typedef logic [41:0] cfg_entry_t;   // {delay_ms, addr_type, data_type, addr, data}
	typedef logic [9:0]  cfg_index_t;   // table index and table size
	typedef logic [15:0] reg_addr_t;    // register address
	typedef logic [15:0] reg_data_t;    // register data
	typedef logic [7:0]  delay_ms_t;    // post-frame wait in ms

	// ----------------------------------------------------------------------
	// bus level
	// ----------------------------------------------------------------------
	typedef logic [7:0]  i2c_byte_t;    // one byte on sda
	typedef logic [3:0]  bit_cnt_t;     // bits shifted, 0..8

	// which byte the shifter loads
	typedef enum logic [2:0] {DEV, ADDR_H, ADDR_L, DATA_H, DATA_L} byte_sel_t;

	// sda action on a transfer strobe
	typedef enum logic [2:0] {HOLD, LOW, HIGH, SHIFT, RELEASE_ACK} sda_cmd_t;

	// write sequence
	typedef enum logic [3:0] {
		IDLE, START, IDADDR, ACK1,
		REGADDR_H, ACK2, REGADDR_L, ACK3,
		REGDATA_H, ACK4, REGDATA_L, ACK5,
		STOP, WAIT
	} wr_state_t;

endpackage

`default_nettype wire

/* i2c_bit_timer.sv */
// bit period divider, gives the transfer and capture strobes and the scl phase
`timescale 1ns/100ps
`default_nettype none
`include "i2c_cfg.svh"

module i2c_bit_timer
(
	input  logic clk,
	input  logic rst_n,
	input  logic powerup_done,  // start dividing once the slave has settled
	output logic transfer_en,   // count 0, sda may change
	output logic capture_en,    // mid period, sda is stable
	output logic scl_phase      // high between one and three quarters
);

	localparam int BIT_CYCLES = `I2C_BIT_CYCLES;
	localparam int CNT_W = $clog2(BIT_CYCLES);

	logic [CNT_W-1:0] div_cnt;  // position within the bit

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			div_cnt <= '0;
			transfer_en <= 1'b0;
			capture_en <= 1'b0;
			scl_phase <= 1'b0;
		end
		else if (powerup_done)
		begin
			if (div_cnt == CNT_W'(BIT_CYCLES - 1))
				div_cnt <= '0;                                        // wrap
			else
				div_cnt <= div_cnt + 1'b1;
			transfer_en <= (div_cnt == '0);
			capture_en <= (div_cnt == CNT_W'(BIT_CYCLES / 2 - 1));
			scl_phase <= (div_cnt >= CNT_W'(BIT_CYCLES / 4)) &&
				(div_cnt < CNT_W'(3 * BIT_CYCLES / 4));               // scl high window
		end
		else
		begin
			div_cnt <= '0;                                            // held until power-up
			transfer_en <= 1'b0;
			capture_en <= 1'b0;
			scl_phase <= 1'b0;
		end
	end

	a_strobes_apart: assert property (@(posedge clk) disable iff (!rst_n)
		!(transfer_en && capture_en));

endmodule

`default_nettype wire

/* i2c_delay_timer.sv */
// power-up settling counter and the per-entry wait in milliseconds after a frame
`timescale 1ns/100ps
`default_nettype none
`include "i2c_cfg.svh"

module i2c_delay_timer
(
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  frame_wait,   // fsm in its post-frame wait
	input  i2c_cfg_pkg::delay_ms_t delay_ms,    // wait of the current entry
	output logic                  powerup_done, // rises once, stays high
	output logic                  wait_done     // requested ms have passed
);

	localparam int PWR_CYCLES = `I2C_POWERUP_CYCLES;
	localparam int MS_CYCLES = `I2C_MS_CYCLES;
	localparam int PWR_W = $clog2(PWR_CYCLES);
	localparam int MS_W = $clog2(MS_CYCLES);

	logic [PWR_W-1:0]      pwr_cnt;
	logic [MS_W-1:0]       ms_cnt;     // clk cycles within one ms
	logic                  ms_tick;
	i2c_cfg_pkg::delay_ms_t tick_cnt;  // whole ms waited
	i2c_cfg_pkg::delay_ms_t delay_lat; // delay of the frame just sent

	// ----------------------------------------------------------------------
	// power-up settling
	// ----------------------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			pwr_cnt <= '0;
			powerup_done <= 1'b0;
		end
		else if (!powerup_done)
		begin
			if (pwr_cnt == PWR_W'(PWR_CYCLES - 1))
				powerup_done <= 1'b1;                  // saturate
			else
				pwr_cnt <= pwr_cnt + 1'b1;
		end
	end

	// ----------------------------------------------------------------------
	// post-frame wait
	// ----------------------------------------------------------------------
	// the index moves on as the wait starts, so the old entry's delay is held
	always_ff @(posedge clk)
	begin
		if (!frame_wait)
			delay_lat <= delay_ms;
	end

	assign ms_tick = (ms_cnt == MS_W'(MS_CYCLES - 1));

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			ms_cnt <= '0;
			tick_cnt <= '0;
		end
		else if (!frame_wait)
		begin
			ms_cnt <= '0;                              // idle while sending
			tick_cnt <= '0;
		end
		else
		begin
			ms_cnt <= ms_tick ? '0 : ms_cnt + 1'b1;
			if (ms_tick && tick_cnt != delay_lat)
				tick_cnt <= tick_cnt + 1'b1;           // stops at the target
		end
	end

	assign wait_done = frame_wait && (tick_cnt == delay_lat);   // zero delay, at once

endmodule

`default_nettype wire

/* i2c_wr_fsm.sv */
// write sequence FSM, steps start, address, register and data bytes, stop and wait
`timescale 1ns/100ps
`default_nettype none

module i2c_wr_fsm
(
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    powerup_done,
	input  logic                    transfer_en,
	input  logic                    scl_phase,
	input  logic                    byte_done,   // eight bits shifted
	input  logic                    ack_fail,    // some ack bit read high
	input  logic                    wait_done,
	input  logic                    addr_type,   // 1: two address bytes
	input  logic                    data_type,   // 1: two data bytes
	input  i2c_cfg_pkg::cfg_index_t cfg_size,
	output i2c_cfg_pkg::cfg_index_t cfg_index,
	output logic                    cfg_done,
	output logic                    frame_wait,
	output logic                    ack_sample,
	output logic                    ack_clear,
	output logic                    scl_oe,      // pulls scl low
	output i2c_cfg_pkg::byte_sel_t  byte_sel,
	output i2c_cfg_pkg::sda_cmd_t   sda_cmd
);

	i2c_cfg_pkg::wr_state_t state, next_state;
	logic                   bit_state;  // scl toggles in byte and ack bits
	logic                   scl_rel;    // scl went high in this bit

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			state <= i2c_cfg_pkg::IDLE;
		else
			state <= next_state;                 // only moves on transfer_en
	end

	always_comb
	begin
		next_state = state;
		if (transfer_en)
		begin
			case (state)
				i2c_cfg_pkg::IDLE:
					if (powerup_done && cfg_index < cfg_size)
						next_state = i2c_cfg_pkg::START;
				i2c_cfg_pkg::START:     next_state = i2c_cfg_pkg::IDADDR;
				i2c_cfg_pkg::IDADDR:    if (byte_done) next_state = i2c_cfg_pkg::ACK1;
				i2c_cfg_pkg::ACK1:      next_state = i2c_cfg_pkg::REGADDR_H;
				i2c_cfg_pkg::REGADDR_H: if (byte_done) next_state = i2c_cfg_pkg::ACK2;
				i2c_cfg_pkg::ACK2:
					if (addr_type)
						next_state = i2c_cfg_pkg::REGADDR_L;   // 16-bit address
					else
						next_state = i2c_cfg_pkg::REGDATA_H;
				i2c_cfg_pkg::REGADDR_L: if (byte_done) next_state = i2c_cfg_pkg::ACK3;
				i2c_cfg_pkg::ACK3:      next_state = i2c_cfg_pkg::REGDATA_H;
				i2c_cfg_pkg::REGDATA_H: if (byte_done) next_state = i2c_cfg_pkg::ACK4;
				i2c_cfg_pkg::ACK4:
					if (data_type)
						next_state = i2c_cfg_pkg::REGDATA_L;   // 16-bit data
					else
						next_state = i2c_cfg_pkg::STOP;
				i2c_cfg_pkg::REGDATA_L: if (byte_done) next_state = i2c_cfg_pkg::ACK5;
				i2c_cfg_pkg::ACK5:      next_state = i2c_cfg_pkg::STOP;
				i2c_cfg_pkg::STOP:      next_state = i2c_cfg_pkg::WAIT;
				i2c_cfg_pkg::WAIT:      if (wait_done) next_state = i2c_cfg_pkg::IDLE;
				default:                next_state = i2c_cfg_pkg::IDLE;
			endcase
		end
	end

	// ----------------------------------------------------------------------
	// shifter commands, decoded from the state being entered
	// ----------------------------------------------------------------------
	always_comb
	begin
		sda_cmd = i2c_cfg_pkg::HOLD;                     // between strobes
		if (transfer_en)
		begin
			case (next_state)
				i2c_cfg_pkg::START, i2c_cfg_pkg::STOP:
					sda_cmd = i2c_cfg_pkg::LOW;
				i2c_cfg_pkg::IDADDR, i2c_cfg_pkg::REGADDR_H, i2c_cfg_pkg::REGADDR_L,
				i2c_cfg_pkg::REGDATA_H, i2c_cfg_pkg::REGDATA_L:
					sda_cmd = i2c_cfg_pkg::SHIFT;
				i2c_cfg_pkg::ACK1, i2c_cfg_pkg::ACK2, i2c_cfg_pkg::ACK3,
				i2c_cfg_pkg::ACK4, i2c_cfg_pkg::ACK5:
					sda_cmd = i2c_cfg_pkg::RELEASE_ACK;      // also loads the next byte
				default:
					sda_cmd = i2c_cfg_pkg::HIGH;             // idle and wait
			endcase
		end
	end

	always_comb
	begin
		case (next_state)
			i2c_cfg_pkg::ACK1: byte_sel = i2c_cfg_pkg::ADDR_H;
			i2c_cfg_pkg::ACK2:
				if (addr_type)
					byte_sel = i2c_cfg_pkg::ADDR_L;
				else
					byte_sel = i2c_cfg_pkg::DATA_H;
			i2c_cfg_pkg::ACK3: byte_sel = i2c_cfg_pkg::DATA_H;
			i2c_cfg_pkg::ACK4: byte_sel = i2c_cfg_pkg::DATA_L;  // unused when data_type is 0
			default:           byte_sel = i2c_cfg_pkg::DEV;
		endcase
	end

	assign ack_sample = next_state inside {i2c_cfg_pkg::ACK1, i2c_cfg_pkg::ACK2,
		i2c_cfg_pkg::ACK3, i2c_cfg_pkg::ACK4, i2c_cfg_pkg::ACK5};
	assign ack_clear = (next_state == i2c_cfg_pkg::START);   // only entered from idle
	assign frame_wait = (state == i2c_cfg_pkg::WAIT);

	// ----------------------------------------------------------------------
	// scl gating
	// ----------------------------------------------------------------------
	assign bit_state = state inside {i2c_cfg_pkg::IDADDR, i2c_cfg_pkg::ACK1,
		i2c_cfg_pkg::REGADDR_H, i2c_cfg_pkg::ACK2, i2c_cfg_pkg::REGADDR_L, i2c_cfg_pkg::ACK3,
		i2c_cfg_pkg::REGDATA_H, i2c_cfg_pkg::ACK4, i2c_cfg_pkg::REGDATA_L, i2c_cfg_pkg::ACK5};

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			scl_rel <= 1'b0;
		else if (transfer_en)
			scl_rel <= 1'b0;
		else if (scl_phase)
			scl_rel <= 1'b1;
	end

	// in STOP scl stays low until sda is down, then is released for good
	assign scl_oe = bit_state ? !scl_phase :
		(state == i2c_cfg_pkg::STOP) ? !(scl_phase || scl_rel) : 1'b0;

	// ----------------------------------------------------------------------
	// table index
	// ----------------------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			cfg_index <= '0;
		else if (transfer_en && state == i2c_cfg_pkg::STOP && !ack_fail && cfg_index < cfg_size)
			cfg_index <= cfg_index + 1'b1;       // a nacked frame repeats
	end

	assign cfg_done = (cfg_index == cfg_size);

	a_state_on_strobe: assert property (@(posedge clk) disable iff (!rst_n)
		!transfer_en |=> $stable(state));
	a_index_bound: assert property (@(posedge clk) disable iff (!rst_n)
		cfg_index <= cfg_size);

endmodule

`default_nettype wire

/* i2c_byte_shifter.sv */
// sda byte shifter, sends the selected byte msb first and gathers the ack bits
`timescale 1ns/100ps
`default_nettype none
`include "i2c_cfg.svh"

module i2c_byte_shifter
(
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   transfer_en,
	input  logic                   capture_en,
	input  logic                   ack_sample,   // current bit is an ack
	input  logic                   ack_clear,    // new frame
	input  logic                   sda_in,
	input  i2c_cfg_pkg::byte_sel_t byte_sel,
	input  i2c_cfg_pkg::sda_cmd_t  sda_cmd,
	input  i2c_cfg_pkg::reg_addr_t entry_addr,
	input  i2c_cfg_pkg::reg_data_t entry_data,
	output logic                   sda_oe,       // pulls sda low
	output logic                   byte_done,
	output logic                   ack_fail
);

	i2c_cfg_pkg::i2c_byte_t load_byte;
	i2c_cfg_pkg::i2c_byte_t shift_reg;
	i2c_cfg_pkg::bit_cnt_t  bit_cnt;
	logic                   sda_out;    // line level wanted, 1 releases

	always_comb
	begin
		case (byte_sel)
			i2c_cfg_pkg::ADDR_H: load_byte = entry_addr[15:8];
			i2c_cfg_pkg::ADDR_L: load_byte = entry_addr[7:0];
			i2c_cfg_pkg::DATA_H: load_byte = entry_data[15:8];
			i2c_cfg_pkg::DATA_L: load_byte = entry_data[7:0];
			default:             load_byte = `I2C_DEVICE_ADDR;   // write address byte
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (transfer_en && (sda_cmd == i2c_cfg_pkg::LOW || sda_cmd == i2c_cfg_pkg::RELEASE_ACK))
			shift_reg <= load_byte;
		else if (transfer_en && sda_cmd == i2c_cfg_pkg::SHIFT)
			shift_reg <= {shift_reg[6:0], 1'b0};                 // msb first
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			sda_out <= 1'b1;
			bit_cnt <= '0;
		end
		else if (transfer_en)
		begin
			case (sda_cmd)
				i2c_cfg_pkg::LOW:         sda_out <= 1'b0;       // start or stop setup
				i2c_cfg_pkg::HIGH:        sda_out <= 1'b1;
				i2c_cfg_pkg::SHIFT:       sda_out <= shift_reg[7];
				i2c_cfg_pkg::RELEASE_ACK: sda_out <= 1'b1;       // slave drives ack
				default:                  sda_out <= sda_out;
			endcase
			if (sda_cmd == i2c_cfg_pkg::SHIFT)
				bit_cnt <= bit_cnt + 1'b1;
			else if (sda_cmd != i2c_cfg_pkg::HOLD)
				bit_cnt <= '0;
		end
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			ack_fail <= 1'b0;
		else if (ack_clear)
			ack_fail <= 1'b0;
		else if (capture_en && ack_sample)
			ack_fail <= ack_fail | sda_in;       // high means nack
	end

	assign byte_done = (bit_cnt == 4'd8);
	assign sda_oe = !sda_out;

	a_bit_cnt_max: assert property (@(posedge clk) disable iff (!rst_n)
		bit_cnt <= 4'd8);
	a_ack_released: assert property (@(posedge clk) disable iff (!rst_n)
		capture_en && ack_sample |-> !sda_oe);

endmodule

`default_nettype wire

/* i2c_cfg_top.sv */
// I2C register configuration master top, walks the user table over open-drain scl and sda
`timescale 1ns/100ps
`default_nettype none

module i2c_cfg_top
(
	input  logic                    clk,
	input  logic                    rst_n,
	input  i2c_cfg_pkg::cfg_index_t cfg_size,   // entries in the table
	input  i2c_cfg_pkg::cfg_entry_t cfg_data,   // entry at cfg_index
	output i2c_cfg_pkg::cfg_index_t cfg_index,
	output logic                    cfg_done,
	output logic                    scl_oe,
	output logic                    sda_oe,
	input  logic                    sda_in
);

	logic                   powerup_done;
	logic                   transfer_en;
	logic                   capture_en;
	logic                   scl_phase;
	logic                   frame_wait;
	logic                   wait_done;
	logic                   byte_done;
	logic                   ack_fail;
	logic                   ack_sample;
	logic                   ack_clear;
	i2c_cfg_pkg::byte_sel_t byte_sel;
	i2c_cfg_pkg::sda_cmd_t  sda_cmd;

	i2c_delay_timer i2c_delay_timer_inst (
		.clk, .rst_n, .frame_wait,
		.delay_ms(cfg_data[41:34]),
		.powerup_done, .wait_done
	);

	i2c_bit_timer i2c_bit_timer_inst (
		.clk, .rst_n, .powerup_done,
		.transfer_en, .capture_en, .scl_phase
	);

	i2c_wr_fsm i2c_wr_fsm_inst (
		.clk, .rst_n, .powerup_done, .transfer_en, .scl_phase,
		.byte_done, .ack_fail, .wait_done,
		.addr_type(cfg_data[33]), .data_type(cfg_data[32]),
		.cfg_size, .cfg_index, .cfg_done, .frame_wait,
		.ack_sample, .ack_clear, .scl_oe, .byte_sel, .sda_cmd
	);

	i2c_byte_shifter i2c_byte_shifter_inst (
		.clk, .rst_n, .transfer_en, .capture_en, .ack_sample, .ack_clear, .sda_in,
		.byte_sel, .sda_cmd,
		.entry_addr(cfg_data[31:16]), .entry_data(cfg_data[15:0]),
		.sda_oe, .byte_done, .ack_fail
	);

endmodule

`default_nettype wire

/* tb_i2c_slave.sv */
// behavioral I2C slave for the testbench, records each write frame and acks or nacks on request
`timescale 1ns/100ps
`default_nettype none

module tb_i2c_slave
(
	input  logic        clk,
	input  logic        rst_n,
	input  logic        scl,          // bus level, after pull-up
	input  logic        sda,
	input  logic        nack_en,      // nack every byte of the next frame
	output logic        sda_oe,       // pulls sda low for an ack
	output int          start_cnt,    // START conditions seen
	output int          start_cyc,    // cycle of the last START
	output int          stop_cyc,     // cycle of the last STOP
	output int          frame_cnt,    // STOP conditions seen
	output int          frame_len,    // bytes in the last frame
	output logic [39:0] frame_bytes   // first byte in the top slot
);

	logic                   scl_q;
	logic                   sda_q;
	int                     bit_cnt;   // 0..7 data, 8 ack
	int                     cyc;
	int                     rx_len;
	i2c_cfg_pkg::i2c_byte_t rx_byte;
	logic [39:0]            rx_bytes;

	// sampled mid-cycle so that bus edges never race the dut clock
	always @(negedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			{scl_q, sda_q} <= 2'b11;      // idle bus
			{sda_oe, bit_cnt, cyc, rx_len, rx_byte, rx_bytes} <= '0;
			{start_cnt, start_cyc, stop_cyc, frame_cnt, frame_len, frame_bytes} <= '0;
		end
		else
		begin
			cyc <= cyc + 1;
			scl_q <= scl;
			sda_q <= sda;
			if (scl && scl_q && sda_q && !sda)
			begin
				start_cnt <= start_cnt + 1;   // start, sda falls with scl high
				start_cyc <= cyc;
				bit_cnt <= 0;
				rx_len <= 0;
				rx_bytes <= '0;
				sda_oe <= 1'b0;
			end
			else if (scl && scl_q && !sda_q && sda)
			begin
				stop_cyc <= cyc;              // stop, sda rises with scl high
				frame_cnt <= frame_cnt + 1;
				frame_len <= rx_len;
				frame_bytes <= rx_bytes;
				bit_cnt <= 0;
			end
			else if (scl && !scl_q)
			begin
				if (bit_cnt < 8)
					rx_byte <= {rx_byte[6:0], sda};   // msb first
				bit_cnt <= bit_cnt + 1;
			end
			else if (!scl && scl_q)
			begin
				if (bit_cnt == 8)
				begin
					if (rx_len < 5)
						rx_bytes[8*(4-rx_len) +: 8] <= rx_byte;
					rx_len <= rx_len + 1;
					sda_oe <= !nack_en;           // ack bit follows
				end
				else if (bit_cnt == 9)
				begin
					sda_oe <= 1'b0;               // ack bit over
					bit_cnt <= 0;
				end
			end
		end
	end

endmodule

`default_nettype wire

/* tb_i2c_cfg_top.sv */
// testbench top, serves a config table to the I2C master and checks every frame on the bus
`timescale 1ns/100ps
`default_nettype none
`include "i2c_cfg.svh"

module tb_i2c_cfg_top;

	localparam int N_ENTRIES = 8;
	localparam int MS_CYCLES = `I2C_MS_CYCLES;
	localparam int FRAME_TIMEOUT = 4 * MS_CYCLES;   // longest wait plus one frame, with margin

	logic                    clk;
	logic                    rst_n;
	i2c_cfg_pkg::cfg_index_t cfg_size;
	i2c_cfg_pkg::cfg_entry_t cfg_data = '0;
	i2c_cfg_pkg::cfg_index_t cfg_index;
	logic                    cfg_done;
	logic                    scl_oe;
	logic                    sda_oe;
	logic                    scl_line;
	logic                    sda_line;
	logic                    slave_sda_oe;
	logic                    nack_en;
	int                      start_cnt;
	int                      start_cyc;
	int                      stop_cyc;
	int                      frame_cnt;
	int                      frame_len;
	logic [39:0]             frame_bytes;

	// ----------------------------------------------------------------------
	// stimulus table, addr and data filled from the xorshift
	// ----------------------------------------------------------------------
	i2c_cfg_pkg::delay_ms_t delay_tbl [N_ENTRIES] = '{8'd1, 8'd0, 8'd2, 8'd0, 8'd1, 8'd0, 8'd0, 8'd1};
	logic [1:0]             type_tbl [N_ENTRIES] = '{2'b00, 2'b11, 2'b01, 2'b10, 2'b00, 2'b11,
		2'b01, 2'b10};                                 // {addr_type, data_type}
	int                     nack_tbl [N_ENTRIES] = '{0, 1, 0, 2, 0, 0, 1, 0};   // frames to nack
	i2c_cfg_pkg::reg_addr_t addr_tbl [N_ENTRIES];
	i2c_cfg_pkg::reg_data_t data_tbl [N_ENTRIES];
	logic [31:0]            rng_state = 32'd35;

	assign scl_line = !scl_oe;                          // pull-ups, wired-and
	assign sda_line = !(sda_oe || slave_sda_oe);

	i2c_cfg_top i2c_cfg_top_inst (
		.clk, .rst_n, .cfg_size, .cfg_data, .cfg_index, .cfg_done,
		.scl_oe, .sda_oe, .sda_in(sda_line)
	);

	tb_i2c_slave i2c_slave_inst (
		.clk, .rst_n, .scl(scl_line), .sda(sda_line), .nack_en, .sda_oe(slave_sda_oe),
		.start_cnt, .start_cyc, .stop_cyc, .frame_cnt, .frame_len, .frame_bytes
	);

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;                          // 4 ns period
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic i2c_cfg_pkg::cfg_entry_t entry_word(input int i);
		return {delay_tbl[i], type_tbl[i], addr_tbl[i], data_tbl[i]};
	endfunction

	// table served by index, data level only
	always @(posedge clk)
	begin
		#1;
		if (cfg_index < cfg_size)
			cfg_data <= entry_word(int'(cfg_index));
		else
			cfg_data <= '0;                             // past the end
	end

	// ----------------------------------------------------------------------
	// checks
	// ----------------------------------------------------------------------
	task automatic fail_run(input string what);
		$display("%s", what);
		$display("Simulation finished: FAIL");
		$fatal(1);
	endtask

	task automatic check_byte(input string name, input i2c_cfg_pkg::i2c_byte_t got,
		input i2c_cfg_pkg::i2c_byte_t exp);
		if (got !== exp)
			fail_run($sformatf("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp));
	endtask

	task automatic check_index(input string name, input i2c_cfg_pkg::cfg_index_t got,
		input i2c_cfg_pkg::cfg_index_t exp);
		if (got !== exp)
			fail_run($sformatf("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp));
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp)
			fail_run($sformatf("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp));
	endtask

	task automatic wait_frame(input int seen);
		int n;
		n = 0;
		while (frame_cnt == seen)
		begin
			@(posedge clk);
			#1;
			n = n + 1;
			if (n > FRAME_TIMEOUT)
				fail_run("timeout, no STOP seen on the bus");
		end
	endtask

	// ----------------------------------------------------------------------
	// main sequence
	// ----------------------------------------------------------------------
	initial
	begin
		int                      i;
		int                      attempt;
		int                      k;
		int                      n_exp;
		int                      seen;
		int                      prev_stop;
		int                      prev_delay;
		i2c_cfg_pkg::cfg_index_t exp_index;
		i2c_cfg_pkg::i2c_byte_t  exp_bytes [5];
		for (i = 0; i < N_ENTRIES; i++)
		begin
			rng_state = xorshift32(rng_state);
			addr_tbl[i] = rng_state[31:16];
			data_tbl[i] = rng_state[15:0];
		end
		rst_n = 1'b0;
		nack_en = 1'b0;
		cfg_size = 10'(N_ENTRIES);
		repeat (16) @(posedge clk);
		#1 rst_n = 1'b1;
		@(posedge clk);
		#1;
		check_bit("scl_oe", scl_oe, 1'b0);              // lines released after reset
		check_bit("sda_oe", sda_oe, 1'b0);
		check_index("cfg_index", cfg_index, '0);
		check_bit("cfg_done", cfg_done, 1'b0);
		seen = 0;
		prev_stop = -1;                                 // no frame yet
		prev_delay = 0;
		exp_index = '0;
		for (i = 0; i < N_ENTRIES; i++)
		begin
			exp_bytes[0] = `I2C_DEVICE_ADDR;
			exp_bytes[1] = addr_tbl[i][15:8];
			n_exp = 2;
			if (type_tbl[i][1])
			begin
				exp_bytes[n_exp] = addr_tbl[i][7:0];    // 16-bit address
				n_exp = n_exp + 1;
			end
			exp_bytes[n_exp] = data_tbl[i][15:8];
			n_exp = n_exp + 1;
			if (type_tbl[i][0])
			begin
				exp_bytes[n_exp] = data_tbl[i][7:0];    // 16-bit data
				n_exp = n_exp + 1;
			end
			for (attempt = 0; attempt <= nack_tbl[i]; attempt++)
			begin
				nack_en = (attempt < nack_tbl[i]);
				wait_frame(seen);
				seen = frame_cnt;
				if (start_cnt != seen)
					fail_run($sformatf("entry %0d frame has no matching START", i));
				if (prev_stop >= 0 && start_cyc - prev_stop < prev_delay * MS_CYCLES)
					fail_run($sformatf("START for entry %0d came before the wait ended", i));
				if (frame_len != n_exp)
					fail_run($sformatf("entry %0d frame has %0d bytes, not %0d", i, frame_len,
						n_exp));
				for (k = 0; k < n_exp; k++)
					check_byte($sformatf("frame byte %0d", k), frame_bytes[8*(4-k) +: 8],
						exp_bytes[k]);
				if (!nack_en)
					exp_index = exp_index + 1'b1;       // only a fully acked frame advances
				check_index("cfg_index", cfg_index, exp_index);
				check_bit("cfg_done", cfg_done, exp_index == 10'(N_ENTRIES));
				prev_stop = stop_cyc;
				prev_delay = int'(delay_tbl[i]);
			end
		end
		nack_en = 1'b0;
		repeat (2 * MS_CYCLES) @(posedge clk);          // quiet window after the last entry
		#1;
		check_bit("cfg_done", cfg_done, 1'b1);
		if (start_cnt != seen)
			fail_run("a START appeared after the table was done");
		else
		begin
			$display("Simulation finished: PASS");
			$finish;
		end
	end

endmodule

`default_nettype wire

/* all.f */
+incdir+.
i2c_cfg_pkg.sv
i2c_bit_timer.sv
i2c_delay_timer.sv
i2c_wr_fsm.sv
i2c_byte_shifter.sv
i2c_cfg_top.sv
tb_i2c_slave.sv
tb_i2c_cfg_top.sv

/* run.sh */
#!/usr/bin/env bash
# compile and run the I2C config master testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/100ps -f all.f \
	--top-module tb_i2c_cfg_top -Mdir obj_dir
./obj_dir/Vtb_i2c_cfg_top > sim.log 2>&1 || true
cat sim.log
if grep -q "Simulation finished: FAIL" sim.log || ! grep -q "Simulation finished: PASS" sim.log; then
	echo "simulation failed, see sim.log"
	exit 1
fi
echo "simulation passed"
